/* src.f */
+incdir+rtl
rtl/mipsPkg.sv
rtl/dataAccessIf.sv
rtl/instrDecoder.sv
rtl/memAccessPrep.sv
rtl/coprocessor0.sv
rtl/memStage.sv
sim/memStageTb.sv

/* sim/memStageTb.sv */
`timescale 1ns/10ps

module memStageTb;

    localparam int MemWords    = 3072;
    localparam int TotalCycles = 60;
    localparam mipsPkg::word_t Nop  = 32'h0000_0000;
    localparam mipsPkg::word_t Addu = 32'h0085_1021;
    localparam mipsPkg::word_t Beq  = 32'h1000_0003;
    localparam mipsPkg::word_t Eret = 32'h4200_0018;
    localparam mipsPkg::word_t PrId = 32'hBAAD_FACE;

    logic clk;
    logic reset;
    logic stall;
    logic clr;
    mipsPkg::word_t     instrMem, pcMem, aluOutMem, dataRtMem, regWriteDataMem;
    mipsPkg::excCode_t  excMem;
    mipsPkg::regAddr_t  addrRtMem, addrRdMem, regWriteAddrMem, regAddrWb;
    mipsPkg::word_t     regDataWb;
    logic [1:0]         tNewMem;
    logic               disDm;
    mipsPkg::word_t     cp0Pc;
    mipsPkg::hwInt_t    hwInt;
    mipsPkg::word_t     instrWb, pcWb, memWordWb, regWriteDataWb;
    logic [1:0]         offsetWb;
    mipsPkg::regAddr_t  regWriteAddrWb;
    logic [1:0]         tNewWb;
    mipsPkg::word_t     dmPc, dmAddr, dmWData, dmRData;
    logic [3:0]         dmWe;
    mipsPkg::kCtrl_t    kCtrl;
    mipsPkg::wordAddr_t epc;
    logic               isBd;

    logic [31:0] memModel [0:MemWords-1];
    logic [31:0] lcgState = 32'h0c8e8918;
    int          errorCount = 0;

    memStage i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Data memory model, combinational read and byte writes on the edge
    assign dmRData = (dmAddr[31:2] < MemWords) ? memModel[dmAddr[13:2]] : 32'h0;

    always @(posedge clk) begin : memWrite
        int lane;
        if (dmAddr[31:2] < MemWords) begin
            for (lane = 0; lane < 4; lane++) begin
                if (dmWe[lane]) begin
                    memModel[dmAddr[13:2]][8*lane +: 8] <= dmWData[8*lane +: 8];
                end
            end
        end
    end

    function logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic logic [31:0] mergeBytes(input logic [31:0] oldWord,
                                               input logic [31:0] newWord,
                                               input logic [3:0] be);
        logic [31:0] result;
        int          lane;
        result = oldWord;
        for (lane = 0; lane < 4; lane++) begin
            if (be[lane]) begin
                result[8*lane +: 8] = newWord[8*lane +: 8];
            end
        end
        return result;
    endfunction

    // Load or store with base in rs 4, rt 8
    function automatic mipsPkg::word_t memOp(input logic [5:0] op);
        return {op, 5'd4, 5'd8, 16'h0000};
    endfunction

    function automatic mipsPkg::word_t cop0Word(input logic [4:0] rs, input logic [4:0] rd);
        return {6'h10, rs, 5'd8, rd, 11'd0};
    endfunction

    task checkValue(input string name, input logic [31:0] actual, input logic [31:0] expected);
        if (actual !== expected) begin
            errorCount++;
            $display("Error %s actual %h expected %h", name, actual, expected);
            $display("SIMULATION FAILED");
            $fatal(1, "Stopping at first mismatch");
        end
    endtask

    task issue(input mipsPkg::word_t instr, input mipsPkg::word_t addr,
               input mipsPkg::word_t rtValue, input mipsPkg::regAddr_t rd);
        @(posedge clk);
        instrMem  <= instr;
        aluOutMem <= addr;
        dataRtMem <= rtValue;
        addrRdMem <= rd;
    endtask

    task settle();
        @(negedge clk);
    endtask

    task testStores();
        logic [31:0] addr, data, expWord;
        logic [1:0]  off;
        logic [3:0]  be;
        addr = (nextRand() % MemWords) << 2;
        data = nextRand();
        issue(memOp(6'h2B), addr, data, 0);
        settle();
        checkValue("dmWe", dmWe, 4'b1111);
        checkValue("dmWData", dmWData, data);
        checkValue("dmAddr", dmAddr, addr);
        expWord = data;
        // Upper halfword
        data = nextRand();
        issue(memOp(6'h29), addr + 2, data, 0);
        settle();
        checkValue("dmWe", dmWe, 4'b1100);
        checkValue("dmWData", dmWData, data << 16);
        checkValue("dmAddr", dmAddr, addr);
        expWord = mergeBytes(expWord, data << 16, 4'b1100);
        // Random byte lane
        off  = nextRand() % 4;
        be   = 4'b0001 << off;
        data = nextRand();
        issue(memOp(6'h28), addr + off, data, 0);
        settle();
        checkValue("memModel", memModel[addr >> 2], expWord);
        checkValue("dmWe", dmWe, be);
        checkValue("dmWData", dmWData, data << (8 * off));
        expWord = mergeBytes(expWord, data << (8 * off), be);
        issue(Nop, 0, 0, 0);
        settle();
        checkValue("dmWe", dmWe, 4'b0000);
        checkValue("memModel", memModel[addr >> 2], expWord);
    endtask

    task testLoadsForwarding();
        logic [31:0] addr, data, fwdData, rtValue;
        addr = (nextRand() % MemWords) << 2;
        data = nextRand();
        issue(memOp(6'h2B), addr, data, 0);
        issue(memOp(6'h23), addr, 0, 0);
        settle();
        issue(memOp(6'h20), addr + 3, 0, 0);
        settle();
        checkValue("memWordWb", memWordWb, data);
        checkValue("regWriteDataWb", regWriteDataWb, data);
        checkValue("offsetWb", offsetWb, 2'd0);
        issue(Nop, 0, 0, 0);
        settle();
        checkValue("memWordWb", memWordWb, data);
        checkValue("offsetWb", offsetWb, 2'd3);
        // Writeback result replaces the stale rt value
        fwdData = nextRand();
        rtValue = nextRand();
        issue(memOp(6'h2B), addr, rtValue, 0);
        addrRtMem <= 5'd9;
        regAddrWb <= 5'd9;
        regDataWb <= fwdData;
        settle();
        checkValue("dmWData", dmWData, fwdData);
        issue(memOp(6'h2B), addr, rtValue, 0);
        addrRtMem <= 5'd0;
        regAddrWb <= 5'd0;
        settle();
        checkValue("dmWData", dmWData, rtValue);
        issue(Nop, 0, 0, 0);
    endtask

    task testPipelineReg();
        logic [31:0] pcA, pcB, dataA, dataB;
        pcA   = nextRand() & 32'hFFFF_FFFC;
        pcB   = nextRand() & 32'hFFFF_FFFC;
        dataA = nextRand();
        dataB = nextRand();
        issue(Addu, 0, 0, 0);
        pcMem           <= pcA;
        regWriteDataMem <= dataA;
        regWriteAddrMem <= 5'd2;
        tNewMem         <= 2'd2;
        issue(Nop, 0, 0, 0);
        stall           <= 1'b1;
        pcMem           <= pcB;
        regWriteDataMem <= dataB;
        regWriteAddrMem <= 5'd3;
        tNewMem         <= 2'd0;
        settle();
        checkValue("dmPc", dmPc, pcB);
        checkValue("instrWb", instrWb, Addu);
        checkValue("pcWb", pcWb, pcA);
        checkValue("regWriteDataWb", regWriteDataWb, dataA);
        checkValue("regWriteAddrWb", regWriteAddrWb, 5'd2);
        checkValue("tNewWb", tNewWb, 2'd1);
        issue(Nop, 0, 0, 0);
        stall <= 1'b0;
        settle();
        checkValue("instrWb", instrWb, Addu);
        checkValue("pcWb", pcWb, pcA);
        checkValue("regWriteDataWb", regWriteDataWb, dataA);
        checkValue("regWriteAddrWb", regWriteAddrWb, 5'd2);
        checkValue("tNewWb", tNewWb, 2'd1);
        issue(Nop, 0, 0, 0);
        clr <= 1'b1;
        settle();
        checkValue("pcWb", pcWb, pcB);
        checkValue("regWriteDataWb", regWriteDataWb, dataB);
        checkValue("regWriteAddrWb", regWriteAddrWb, 5'd3);
        checkValue("tNewWb", tNewWb, 2'd0);
        issue(Nop, 0, 0, 0);
        clr     <= 1'b0;
        tNewMem <= 2'd3;
        settle();
        checkValue("pcWb", pcWb, 32'h0);
        checkValue("memWordWb", memWordWb, 32'h0);
        checkValue("regWriteDataWb", regWriteDataWb, 32'h0);
        checkValue("regWriteAddrWb", regWriteAddrWb, 5'd0);
        checkValue("tNewWb", tNewWb, 2'd0);
        issue(Nop, 0, 0, 0);
        tNewMem <= 2'd0;
        settle();
        checkValue("tNewWb", tNewWb, 2'd2);
    endtask

    // One faulting access, then read Cause and EPC back
    task excCase(input mipsPkg::word_t instr, input mipsPkg::word_t addr,
                 input logic [4:0] expCode);
        logic [31:0] pc;
        pc = nextRand() & 32'h0000_FFFC;
        issue(instr, addr, nextRand(), 0);
        cp0Pc <= pc;
        settle();
        checkValue("kCtrl", kCtrl, mipsPkg::kKtext);
        checkValue("isBd", isBd, 1'b0);
        issue(cop0Word(5'h00, 5'd13), 0, 0, 5'd13);
        issue(cop0Word(5'h00, 5'd14), 0, 0, 5'd14);
        settle();
        checkValue("Cause.ExcCode", (regWriteDataWb >> 2) & 32'h1F, expCode);
        issue(Nop, 0, 0, 0);
        settle();
        checkValue("EPC", regWriteDataWb, pc);
    endtask

    task testAddrExceptions();
        excCase(memOp(6'h23), 32'h0000_0102, 5'd4);
        excCase(memOp(6'h21), 32'h0000_7F00, 5'd4);
        excCase(memOp(6'h2B), 32'h0000_8000, 5'd5);
        excCase(memOp(6'h2B), 32'h0000_7F08, 5'd5);
    endtask

    task testInterrupts();
        // IM cleared, IE set
        issue(cop0Word(5'h04, 5'd12), 0, 32'h0000_0001, 5'd12);
        issue(Nop, 0, 0, 0);
        hwInt <= 6'b000100;
        settle();
        checkValue("kCtrl", kCtrl, mipsPkg::kNone);
        issue(cop0Word(5'h04, 5'd12), 0, 32'h0000_FC01, 5'd12);
        settle();
        checkValue("kCtrl", kCtrl, mipsPkg::kNone);
        issue(Nop, 0, 0, 0);
        settle();
        checkValue("kCtrl", kCtrl, mipsPkg::kKtext);
        issue(Nop, 0, 0, 0);
        settle();
        checkValue("kCtrl", kCtrl, mipsPkg::kNone);
        issue(Eret, 0, 0, 0);
        settle();
        checkValue("kCtrl", kCtrl, mipsPkg::kEret);
        issue(Nop, 0, 0, 0);
        settle();
        checkValue("kCtrl", kCtrl, mipsPkg::kKtext);
        issue(Eret, 0, 0, 0);
        hwInt <= 6'b000000;
        settle();
        checkValue("kCtrl", kCtrl, mipsPkg::kEret);
    endtask

    task testDelaySlot();
        logic [31:0] pc;
        pc = (nextRand() & 32'h0000_FFFC) | 32'h0000_0100;
        issue(Beq, 0, 0, 0);
        issue(memOp(6'h23), 32'h0000_0102, 0, 0);
        cp0Pc <= pc;
        settle();
        checkValue("kCtrl", kCtrl, mipsPkg::kKtext);
        checkValue("isBd", isBd, 1'b1);
        issue(cop0Word(5'h00, 5'd13), 0, 0, 5'd13);
        settle();
        checkValue("epc", {epc, 2'b00}, pc - 32'd4);
        issue(cop0Word(5'h00, 5'd15), 0, 0, 5'd15);
        settle();
        checkValue("Cause.BD", regWriteDataWb >> 31, 32'h1);
        issue(Nop, 0, 0, 0);
        settle();
        checkValue("PrID", regWriteDataWb, PrId);
    endtask

    initial begin
        int i;
        for (i = 0; i < MemWords; i++) begin
            memModel[i] = (i * 32'h0001_0003) ^ 32'hC3A5_0000;
        end
        reset           = 1'b1;
        stall           = 1'b0;
        clr             = 1'b0;
        instrMem        = Nop;
        pcMem           = 32'h0;
        aluOutMem       = 32'h0;
        dataRtMem       = 32'h0;
        regWriteDataMem = 32'h0;
        excMem          = 5'd0;
        addrRtMem       = 5'd0;
        addrRdMem       = 5'd0;
        regWriteAddrMem = 5'd0;
        regAddrWb       = 5'd0;
        regDataWb       = 32'h0;
        tNewMem         = 2'd0;
        disDm           = 1'b0;
        cp0Pc           = 32'h0;
        hwInt           = 6'd0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        testStores();
        testLoadsForwarding();
        testPipelineReg();
        testAddrExceptions();
        testInterrupts();
        testDelaySlot();
        if (errorCount == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            $display("SIMULATION FAILED");
            $fatal(1, "Checks reported mismatches");
        end
    end

    // Watchdog
    initial begin
        #(TotalCycles * 100 + 1000);
        $display("Timeout: the tests did not finish in the expected time");
        $display("SIMULATION FAILED");
        $fatal(1, "Watchdog expired");
    end

endmodule

/* rtl/memStage.sv */
`timescale 1ns/10ps

module memStage (
    input  logic                clk,
    input  logic                reset,
    input  logic                stall,
    input  logic                clr,
    // From execute
    input  mipsPkg::word_t      instrMem,
    input  mipsPkg::word_t      pcMem,
    input  mipsPkg::word_t      aluOutMem,
    input  mipsPkg::word_t      dataRtMem,
    input  mipsPkg::word_t      regWriteDataMem,
    input  mipsPkg::excCode_t   excMem,
    input  mipsPkg::regAddr_t   addrRtMem,
    input  mipsPkg::regAddr_t   addrRdMem,
    input  mipsPkg::regAddr_t   regWriteAddrMem,
    input  logic [1:0]          tNewMem,
    // Forwarding from writeback
    input  mipsPkg::regAddr_t   regAddrWb,
    input  mipsPkg::word_t      regDataWb,
    input  logic                disDm,
    input  mipsPkg::word_t      cp0Pc,
    input  mipsPkg::hwInt_t     hwInt,
    // MEM/WB register
    output mipsPkg::word_t      instrWb,
    output mipsPkg::word_t      pcWb,
    output mipsPkg::word_t      memWordWb,
    output logic [1:0]          offsetWb,
    output mipsPkg::regAddr_t   regWriteAddrWb,
    output mipsPkg::word_t      regWriteDataWb,
    output logic [1:0]          tNewWb,
    // Data memory bus
    output mipsPkg::word_t      dmPc,
    output mipsPkg::word_t      dmAddr,
    output mipsPkg::word_t      dmWData,
    output logic [3:0]          dmWe,
    input  mipsPkg::word_t      dmRData,
    // Kernel control
    output mipsPkg::kCtrl_t     kCtrl,
    output mipsPkg::wordAddr_t  epc,
    output logic                isBd
);

    mipsPkg::instrKind_t kindMem;
    mipsPkg::funcClass_t funcClassMem;
    mipsPkg::funcClass_t funcClassWb;
    mipsPkg::word_t      rtData;
    mipsPkg::excCode_t   excMerged;
    mipsPkg::word_t      cp0Data;
    mipsPkg::word_t      regWriteData;
    logic [1:0]          tNew;

    dataAccessIf acc ();

    instrDecoder i_decMem (
        .instr     (instrMem),
        .kind      (kindMem),
        .funcClass (funcClassMem)
    );

    // Writeback instruction, for the delay-slot check
    instrDecoder i_decWb (
        .instr     (instrWb),
        .kind      (),
        .funcClass (funcClassWb)
    );

    // Register 0 never forwards
    assign rtData = (regAddrWb == addrRtMem && regAddrWb != 5'd0) ? regDataWb : dataRtMem;

    memAccessPrep i_prep (
        .kind      (kindMem),
        .funcClass (funcClassMem),
        .addr      (aluOutMem),
        .storeData (rtData),
        .enable    (!disDm),
        .acc       (acc.prep)
    );

    assign dmPc    = pcMem;
    assign dmAddr  = {acc.wordAddr, 2'b00};
    assign dmWe    = acc.byteEnable;
    assign dmWData = acc.storeData;

    // Address fault in this stage outranks older exceptions
    assign excMerged = (acc.exc != mipsPkg::excInt) ? acc.exc : excMem;

    coprocessor0 i_cp0 (
        .clk           (clk),
        .reset         (reset),
        .pc            (cp0Pc),
        .wData         (rtData),
        .regId         (addrRdMem),
        .kind          (kindMem),
        .prevFuncClass (funcClassWb),
        .hwInt         (hwInt),
        .exc           (excMerged),
        .kCtrl         (kCtrl),
        .isBd          (isBd),
        .epc           (epc),
        .rData         (cp0Data)
    );

    always_comb begin
        if (kindMem == mipsPkg::instrMfc0) begin
            regWriteData = cp0Data;
        end else if (funcClassMem == mipsPkg::fcMemRead) begin
            regWriteData = dmRData;
        end else begin
            regWriteData = regWriteDataMem;
        end
    end

    assign tNew = (tNewMem != 2'd0) ? (tNewMem - 2'd1) : 2'd0;

    always_ff @(posedge clk) begin
        if (reset || clr) begin
            instrWb        <= '0;
            pcWb           <= '0;
            memWordWb      <= '0;
            offsetWb       <= '0;
            regWriteAddrWb <= '0;
            regWriteDataWb <= '0;
            tNewWb         <= '0;
        end else if (!stall) begin
            instrWb        <= instrMem;
            pcWb           <= pcMem;
            memWordWb      <= dmRData;
            offsetWb       <= acc.offset;
            regWriteAddrWb <= regWriteAddrMem;
            regWriteDataWb <= regWriteData;
            tNewWb         <= tNew;
        end
    end

endmodule

/* rtl/coprocessor0.sv */
`timescale 1ns/10ps
`include "memStage_config.svh"

module coprocessor0 (
    input  logic                clk,
    input  logic                reset,
    input  mipsPkg::word_t      pc,
    input  mipsPkg::word_t      wData,
    input  mipsPkg::regAddr_t   regId,
    input  mipsPkg::instrKind_t kind,
    input  mipsPkg::funcClass_t prevFuncClass,
    input  mipsPkg::hwInt_t     hwInt,
    input  mipsPkg::excCode_t   exc,
    output mipsPkg::kCtrl_t     kCtrl,
    output logic                isBd,
    output mipsPkg::wordAddr_t  epc,
    output mipsPkg::word_t      rData
);

    localparam mipsPkg::word_t TextStart = `TEXT_START;
    localparam mipsPkg::word_t PrId      = `PRID_VALUE;

    // SR fields
    mipsPkg::hwInt_t    im;
    logic               exl;
    logic               ie;
    // Cause fields
    mipsPkg::hwInt_t    ip;
    mipsPkg::excCode_t  excCode;
    logic               bd;
    mipsPkg::wordAddr_t epcReg;

    mipsPkg::word_t     sr;
    mipsPkg::word_t     cause;
    mipsPkg::word_t     entryPc;
    logic               interrupt;
    logic               entry;
    logic               isEret;
    logic               isMtc0;
    logic               delaySlot;

    assign sr    = {16'b0, im, 8'b0, exl, ie};
    assign cause = {bd, 15'b0, ip, 3'b0, excCode, 2'b0};
    assign epc   = epcReg;

    assign interrupt = (|(im & hwInt)) && ie && !exl;
    assign entry     = interrupt || (exc != mipsPkg::excInt);
    assign isEret    = (kind == mipsPkg::instrEret);
    assign isMtc0    = (kind == mipsPkg::instrMtc0);

    // Instruction in writeback was a branch or jump, so this one is its delay slot
    assign delaySlot = (prevFuncClass == mipsPkg::fcBranch) ||
                       (prevFuncClass == mipsPkg::fcJump);
    assign entryPc   = delaySlot ? (pc - 32'd4) : pc;

    assign kCtrl = entry  ? mipsPkg::kKtext :
                   isEret ? mipsPkg::kEret  : mipsPkg::kNone;
    assign isBd  = entry && delaySlot;

    always_comb begin
        rData = '0;
        if (kind == mipsPkg::instrMfc0) begin
            case (regId)
                `CP0_SR:    rData = sr;
                `CP0_CAUSE: rData = cause;
                `CP0_EPC:   rData = {epcReg, 2'b00};
                `CP0_PRID:  rData = PrId;
                default:    rData = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            im      <= '1;
            exl     <= 1'b0;
            ie      <= 1'b1;
            ip      <= '0;
            excCode <= mipsPkg::excInt;
            bd      <= 1'b0;
            epcReg  <= TextStart[31:2];
        end else begin
            ip <= hwInt;
            if (isEret) begin
                exl     <= 1'b0;
                excCode <= mipsPkg::excInt;
                bd      <= 1'b0;
            end else if (entry) begin
                exl     <= 1'b1;
                // Interrupts carry the zero code
                excCode <= exc;
                bd      <= delaySlot;
            end else if (isMtc0 && regId == `CP0_SR) begin
                im  <= wData[15:10];
                exl <= wData[1];
                ie  <= wData[0];
            end
            if (entry) begin
                epcReg <= entryPc[31:2];
            end else if (isMtc0 && regId == `CP0_EPC) begin
                epcReg <= wData[31:2];
            end
        end
    end

    // A return reported to the controller really leaves exception level
    eretLeavesExl: assert property (
        @(posedge clk) disable iff (reset) kCtrl == mipsPkg::kEret |=> !exl && !bd
    );

    // Entry without a simultaneous ERET leaves the core in exception level
    exlAfterEntry: assert property (
        @(posedge clk) disable iff (reset) (entry && !isEret) |=> exl
    );

    // Cause.BD only rises after an entry flagged as a delay slot
    bdFromDelaySlotEntry: assert property (
        @(posedge clk) disable iff (reset) $rose(bd) |-> $past(isBd)
    );

endmodule

/* rtl/memAccessPrep.sv */
`timescale 1ns/10ps
`include "memStage_config.svh"

module memAccessPrep (
    input  mipsPkg::instrKind_t kind,
    input  mipsPkg::funcClass_t funcClass,
    input  mipsPkg::word_t      addr,
    input  mipsPkg::word_t      storeData,
    input  logic                enable,
    dataAccessIf.prep           acc
);

    logic [1:0] offset;
    logic       inData;
    logic       inAnyRange;
    logic       isWordAcc;
    logic       isHalfAcc;
    logic       isLoad;
    logic       isStore;
    logic       toCountReg;

    function automatic logic inRange(
        input mipsPkg::word_t a,
        input mipsPkg::word_t lo,
        input mipsPkg::word_t hi
    );
        return (a >= lo) && (a <= hi);
    endfunction

    assign offset       = addr[1:0];
    assign acc.wordAddr = addr[31:2];
    assign acc.offset   = offset;

    assign isLoad  = (funcClass == mipsPkg::fcMemRead);
    assign isStore = (funcClass == mipsPkg::fcMemWrite);

    // Word and halfword accesses of either direction
    assign isWordAcc = (kind == mipsPkg::instrLw) || (kind == mipsPkg::instrSw);
    assign isHalfAcc = (kind == mipsPkg::instrLh) || (kind == mipsPkg::instrLhu) ||
                       (kind == mipsPkg::instrSh);

    assign inData     = inRange(addr, `DATA_START, `DATA_END);
    assign inAnyRange = inData ||
                        inRange(addr, `TIMER0_START, `TIMER0_END) ||
                        inRange(addr, `TIMER1_START, `TIMER1_END);
    assign toCountReg = (addr == `TIMER0_COUNT) || (addr == `TIMER1_COUNT);

    // Lane enables
    always_comb begin
        acc.byteEnable = 4'b0000;
        if (enable && isStore) begin
            case (kind)
                mipsPkg::instrSw: acc.byteEnable = 4'b1111;
                mipsPkg::instrSh: acc.byteEnable = offset[1] ? 4'b1100 : 4'b0011;
                mipsPkg::instrSb: acc.byteEnable = 4'b0001 << offset;
                default:          acc.byteEnable = 4'b0000;
            endcase
        end
    end

    // Move store data onto its byte lanes
    always_comb begin
        case (kind)
            mipsPkg::instrSh: acc.storeData = storeData << {offset[1], 4'b0000};
            mipsPkg::instrSb: acc.storeData = storeData << {offset, 3'b000};
            default:          acc.storeData = storeData;
        endcase
    end

    // Address checks, first match wins
    always_comb begin
        acc.exc = mipsPkg::excInt;
        if (isLoad) begin
            if ((isWordAcc && offset != 2'b00) || (isHalfAcc && offset[0])) begin
                acc.exc = mipsPkg::excAdEL;
            end else if (isHalfAcc && !inData) begin
                acc.exc = mipsPkg::excAdEL;
            end else if (!inAnyRange) begin
                acc.exc = mipsPkg::excAdEL;
            end
        end else if (isStore) begin
            if ((isWordAcc && offset != 2'b00) || (isHalfAcc && offset[0])) begin
                acc.exc = mipsPkg::excAdES;
            end else if (kind != mipsPkg::instrSw && !inData) begin
                // Sub-word stores only reach data RAM
                acc.exc = mipsPkg::excAdES;
            end else if (!inAnyRange || toCountReg) begin
                acc.exc = mipsPkg::excAdES;
            end
        end
    end

endmodule

/* rtl/instrDecoder.sv */
`timescale 1ns/10ps

module instrDecoder (
    input  mipsPkg::word_t      instr,
    output mipsPkg::instrKind_t kind,
    output mipsPkg::funcClass_t funcClass
);

    logic [5:0] opcode;
    logic [5:0] funct;
    logic [4:0] rs;
    logic [4:0] rt;

    assign opcode = instr[31:26];
    assign rs     = instr[25:21];
    assign rt     = instr[20:16];
    assign funct  = instr[5:0];

    always_comb begin
        kind = mipsPkg::instrOther;
        case (opcode)
            // JR and JALR
            6'h00: if (funct == 6'h08 || funct == 6'h09) kind = mipsPkg::instrJump;
            // REGIMM, BLTZ when rt is 0, BGEZ when rt is 1
            6'h01: if (rt == 5'd0 || rt == 5'd1) kind = mipsPkg::instrBranch;
            6'h02, 6'h03: kind = mipsPkg::instrJump;
            6'h04, 6'h05, 6'h06, 6'h07: kind = mipsPkg::instrBranch;
            6'h10: begin
                if (rs == 5'h00) begin
                    kind = mipsPkg::instrMfc0;
                end else if (rs == 5'h04) begin
                    kind = mipsPkg::instrMtc0;
                end else if (rs == 5'h10 && funct == 6'h18) begin
                    kind = mipsPkg::instrEret;
                end
            end
            6'h20: kind = mipsPkg::instrLb;
            6'h21: kind = mipsPkg::instrLh;
            6'h23: kind = mipsPkg::instrLw;
            6'h24: kind = mipsPkg::instrLbu;
            6'h25: kind = mipsPkg::instrLhu;
            6'h28: kind = mipsPkg::instrSb;
            6'h29: kind = mipsPkg::instrSh;
            6'h2B: kind = mipsPkg::instrSw;
            default: kind = mipsPkg::instrOther;
        endcase
    end

    always_comb begin
        case (kind)
            mipsPkg::instrLw, mipsPkg::instrLh, mipsPkg::instrLhu,
            mipsPkg::instrLb, mipsPkg::instrLbu:                 funcClass = mipsPkg::fcMemRead;
            mipsPkg::instrSw, mipsPkg::instrSh, mipsPkg::instrSb: funcClass = mipsPkg::fcMemWrite;
            mipsPkg::instrMfc0, mipsPkg::instrMtc0,
            mipsPkg::instrEret:                                  funcClass = mipsPkg::fcCp0;
            mipsPkg::instrBranch:                                funcClass = mipsPkg::fcBranch;
            mipsPkg::instrJump:                                  funcClass = mipsPkg::fcJump;
            default:                                             funcClass = mipsPkg::fcOther;
        endcase
    end

endmodule

/* rtl/dataAccessIf.sv */
`timescale 1ns/10ps

// Prepared data-memory access
interface dataAccessIf;
    mipsPkg::wordAddr_t wordAddr;
    logic [3:0]         byteEnable;
    mipsPkg::word_t     storeData;
    logic [1:0]         offset;
    mipsPkg::excCode_t  exc;

    modport prep (
        output wordAddr, byteEnable, storeData, offset, exc
    );

    modport stage (
        input wordAddr, byteEnable, storeData, offset, exc
    );

endinterface

/* rtl/mipsPkg.sv */
package mipsPkg;

    // Data and instruction words
    typedef logic [31:0] word_t;

    // Address bits 31..2
    typedef logic [29:0] wordAddr_t;

    // GPR or CP0 register number
    typedef logic [4:0] regAddr_t;

    // Cause.ExcCode field
    typedef logic [4:0] excCode_t;

    // Hardware interrupt lines 7..2
    typedef logic [5:0] hwInt_t;

    parameter excCode_t excInt  = 5'd0;
    parameter excCode_t excAdEL = 5'd4;
    parameter excCode_t excAdES = 5'd5;

    // Instructions the memory stage cares about
    typedef enum logic [3:0] {
        instrOther,
        instrLw,
        instrLh,
        instrLhu,
        instrLb,
        instrLbu,
        instrSw,
        instrSh,
        instrSb,
        instrMfc0,
        instrMtc0,
        instrEret,
        instrBranch,
        instrJump
    } instrKind_t;

    typedef enum logic [2:0] {
        fcOther,
        fcMemRead,
        fcMemWrite,
        fcCp0,
        fcBranch,
        fcJump
    } funcClass_t;

    // Request to the pipeline controller
    typedef enum logic [1:0] {
        kNone  = 2'd0,
        kKtext = 2'd1,
        kEret  = 2'd2
    } kCtrl_t;

endpackage

/* rtl/memStage_config.svh */
`ifndef MEM_STAGE_CONFIG_SVH
`define MEM_STAGE_CONFIG_SVH

// Data RAM window, byte addresses
`define DATA_START      32'h0000_0000
`define DATA_END        32'h0000_2FFF

// Timer register windows
`define TIMER0_START    32'h0000_7F00
`define TIMER0_END      32'h0000_7F0B
`define TIMER1_START    32'h0000_7F10
`define TIMER1_END      32'h0000_7F1B

// Count registers are read-only
`define TIMER0_COUNT    32'h0000_7F08
`define TIMER1_COUNT    32'h0000_7F18

// First user instruction, also the EPC value after reset
`define TEXT_START      32'h0000_3000

// Kernel handler entry
`define KTEXT_START     32'h0000_4180

// Processor ID returned by MFC0
`define PRID_VALUE      32'hBAAD_FACE

// Coprocessor 0 register numbers
`define CP0_SR          5'd12
`define CP0_CAUSE       5'd13
`define CP0_EPC         5'd14
`define CP0_PRID        5'd15

`endif
